/* common/cache_pkg.sv */
//==========================================================================
// L1 data cache shared definitions
// Geometry, address split, line layout, opcodes and bus tags
//==========================================================================

package cache_pkg;

  // Cache geometry, 4 ways x 4 sets x 64 B
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 4;
  localparam int LINE_BYTES     = 64;
  localparam int BEATS_PER_LINE = 8;
  localparam int WAY_W          = $clog2(NUM_WAYS);

  // Address and data widths
  localparam int ADDR_W   = 64;
  localparam int DATA_W   = 64;
  localparam int OFFSET_W = 6;
  localparam int INDEX_W  = 2;
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

  // Byte address split, tag in the top bits
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } cache_addr_t;

  // One line, beat 0 in the low 64 bits
  typedef logic [BEATS_PER_LINE-1:0][DATA_W-1:0] cache_line_t;

  // Loads first, then stores
  typedef enum logic [3:0] {
    LD, LW, LH, LB, LWU, LHU, LBU,
    SD, SW, SH, SB
  } mem_op_e;

  // Memory request tags
  typedef enum logic [1:0] {
    MEM_READ  = 2'b01,
    MEM_WRITE = 2'b10
  } bus_tag_e;

  // CPU access, held for the whole access
  typedef struct packed {
    logic              write;
    cache_addr_t       addr;
    logic [DATA_W-1:0] value;
    mem_op_e           op;
  } cpu_req_t;

  // One request bus beat, address or data
  typedef struct packed {
    logic [DATA_W-1:0] data;
    bus_tag_e          tag;
  } bus_req_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE, LOOKUP, WRITE_BACK, FILL, REFILL
  } ctrl_state_e;

endpackage

/* rtl/load_store_align.sv */
//==========================================================================
// Load extract and store merge
// Sized, extended loads from a line and byte-merged store lines
//==========================================================================
`timescale 1ns/1ps

module load_store_align (
  input  cache_pkg::cache_line_t          line,
  input  logic [cache_pkg::OFFSET_W-1:0]  offset,
  input  cache_pkg::mem_op_e              op,
  input  logic [cache_pkg::DATA_W-1:0]    store_value,
  output logic [cache_pkg::DATA_W-1:0]    load_value,
  output cache_pkg::cache_line_t          merged_line
);
  import cache_pkg::*;

  logic [LINE_BYTES*8-1:0] shifted;
  logic [LINE_BYTES*8-1:0] byte_mask;
  logic [LINE_BYTES*8-1:0] insert;
  logic [DATA_W-1:0]       size_mask;
  logic [OFFSET_W+2:0]     bit_shift;

  // Byte offset as a bit count
  assign bit_shift = {offset, 3'b000};

  always_comb begin
    shifted = line >> bit_shift;
    case (op)
      LW:      load_value = {{32{shifted[31]}}, shifted[31:0]};
      LH:      load_value = {{48{shifted[15]}}, shifted[15:0]};
      LB:      load_value = {{56{shifted[7]}}, shifted[7:0]};
      LWU:     load_value = {32'b0, shifted[31:0]};
      LHU:     load_value = {48'b0, shifted[15:0]};
      LBU:     load_value = {56'b0, shifted[7:0]};
      default: load_value = shifted[DATA_W-1:0];
    endcase
  end

  always_comb begin
    // Loads leave the line untouched
    case (op)
      SD:      size_mask = '1;
      SW:      size_mask = 64'h0000_0000_FFFF_FFFF;
      SH:      size_mask = 64'h0000_0000_0000_FFFF;
      SB:      size_mask = 64'h0000_0000_0000_00FF;
      default: size_mask = '0;
    endcase
    byte_mask   = {{(LINE_BYTES*8-DATA_W){1'b0}}, size_mask} << bit_shift;
    insert      = {{(LINE_BYTES*8-DATA_W){1'b0}}, store_value & size_mask} << bit_shift;
    merged_line = (line & ~byte_mask) | insert;
  end

endmodule

/* cache/tag_data_array.sv */
//==========================================================================
// Tag, state and data storage
// Four-way lookup, LFSR victim choice, fill and store-merge writes
//==========================================================================
`timescale 1ns/1ps

module tag_data_array (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [cache_pkg::INDEX_W-1:0]  index,
  input  logic [cache_pkg::TAG_W-1:0]    tag,
  input  logic                           line_we,
  input  logic                           line_dirty,
  input  logic                           hit_update,
  input  cache_pkg::cache_line_t         fill_line,
  input  cache_pkg::cache_line_t         merged_line,
  output logic                           hit,
  output logic                           victim_dirty,
  output cache_pkg::cache_line_t         hit_line,
  output cache_pkg::cache_line_t         victim_line,
  output logic [cache_pkg::TAG_W-1:0]    victim_tag
);
  import cache_pkg::*;

  // Storage, way-major
  logic [TAG_W-1:0]                   tags [NUM_WAYS][NUM_SETS];
  cache_line_t                        data [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0][NUM_SETS-1:0]  valid_q;
  logic [NUM_WAYS-1:0][NUM_SETS-1:0]  dirty_q;

  logic [WAY_W-1:0] hit_way;
  logic [WAY_W-1:0] victim_q;
  logic [WAY_W-1:0] sel_way;
  logic             victim_locked;
  logic [7:0]       lfsr;

  // Parallel tag compare
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (valid_q[w][index] && (tags[w][index] == tag)) begin
        hit     = 1'b1;
        hit_way = WAY_W'(w);
      end
    end
  end

  // Live LFSR until the miss locks a way
  assign sel_way      = victim_locked ? victim_q : lfsr[WAY_W-1:0];
  assign hit_line     = data[hit_way][index];
  assign victim_line  = data[sel_way][index];
  assign victim_tag   = tags[sel_way][index];
  assign victim_dirty = valid_q[sel_way][index] && dirty_q[sel_way][index];

  // Free-running, x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk) begin
    if (!reset) begin
      lfsr          <= 8'hA5;
      victim_q      <= '0;
      victim_locked <= 1'b0;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      if (!hit && !victim_locked) begin
        victim_q      <= lfsr[WAY_W-1:0];
        victim_locked <= 1'b1;
      end else if (line_we) begin
        // Next miss draws a fresh way
        victim_locked <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (line_we) begin
      valid_q[sel_way][index] <= 1'b1;
      dirty_q[sel_way][index] <= line_dirty;
    end else if (hit_update) begin
      dirty_q[hit_way][index] <= 1'b1;
    end
  end

  // Fill into the victim, store merge into the hit way
  always_ff @(posedge clk) begin
    if (line_we) begin
      tags[sel_way][index] <= tag;
      data[sel_way][index] <= fill_line;
    end else if (hit_update) begin
      data[hit_way][index] <= merged_line;
    end
  end

endmodule

/* cache/bus_engine.sv */
//==========================================================================
// Memory bus engine
// Sends fill and write-back requests, collects fill beats into a line
//==========================================================================
`timescale 1ns/1ps

module bus_engine (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          fill_start,
  input  logic                          wb_start,
  input  logic [cache_pkg::ADDR_W-1:0]  fill_addr,
  input  logic [cache_pkg::ADDR_W-1:0]  wb_addr,
  input  cache_pkg::cache_line_t        wb_line,
  output logic                          req_cyc,
  output cache_pkg::bus_req_t           bus_req,
  input  logic                          req_ack,
  input  logic                          resp_cyc,
  input  logic [cache_pkg::DATA_W-1:0]  resp_data,
  output logic                          resp_ack,
  output cache_pkg::cache_line_t        fill_line,
  output logic                          fill_done,
  output logic                          wb_done
);
  import cache_pkg::*;

  logic        wb_active;
  logic        wb_data;
  logic [2:0]  req_cnt;
  logic [2:0]  next_cnt;
  logic [2:0]  resp_cnt;
  logic        req_accept;
  logic        last_beat;
  cache_line_t line_buf;

  assign req_accept = req_cyc && req_ack;
  assign next_cnt   = req_cnt + 3'd1;
  assign last_beat  = wb_data && (req_cnt == 3'(BEATS_PER_LINE - 1));
  assign fill_line  = line_buf;

  always_ff @(posedge clk) begin
    if (!reset) begin
      req_cyc   <= 1'b0;
      wb_active <= 1'b0;
      wb_data   <= 1'b0;
      req_cnt   <= '0;
      wb_done   <= 1'b0;
      resp_cnt  <= '0;
      resp_ack  <= 1'b0;
      fill_done <= 1'b0;
    end else begin
      wb_done   <= 1'b0;
      fill_done <= 1'b0;
      // One acknowledge per captured beat
      resp_ack  <= resp_cyc;
      if (wb_start) begin
        req_cyc   <= 1'b1;
        wb_active <= 1'b1;
        wb_data   <= 1'b0;
        req_cnt   <= '0;
      end else if (fill_start) begin
        req_cyc  <= 1'b1;
        resp_cnt <= '0;
      end else if (req_accept) begin
        if (!wb_active) begin
          // Fill is a single address beat
          req_cyc <= 1'b0;
        end else if (!wb_data) begin
          wb_data <= 1'b1;
        end else if (last_beat) begin
          req_cyc   <= 1'b0;
          wb_active <= 1'b0;
          wb_data   <= 1'b0;
          wb_done   <= 1'b1;
        end else begin
          req_cnt <= next_cnt;
        end
      end
      if (resp_cyc) begin
        resp_cnt  <= resp_cnt + 3'd1;
        fill_done <= (resp_cnt == 3'(BEATS_PER_LINE - 1));
      end
    end
  end

  // Beat payload holds until accepted
  always_ff @(posedge clk) begin
    if (wb_start) begin
      bus_req.data <= wb_addr;
      bus_req.tag  <= MEM_WRITE;
      line_buf     <= wb_line;
    end else if (fill_start) begin
      bus_req.data <= fill_addr;
      bus_req.tag  <= MEM_READ;
    end else if (req_accept && wb_active) begin
      // Address beat first, then beats 0 to 7
      bus_req.data <= wb_data ? line_buf[next_cnt] : line_buf[0];
    end
    if (resp_cyc) begin
      line_buf[resp_cnt] <= resp_data;
    end
  end

endmodule

/* cache/cache_ctrl.sv */
//==========================================================================
// Cache access controller
// Sequences lookup, victim write-back, line fill and replay
//==========================================================================
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          access,
  input  cache_pkg::cpu_req_t           cpu_req,
  input  logic                          hit,
  input  logic                          victim_dirty,
  input  logic [cache_pkg::DATA_W-1:0]  load_value,
  output logic                          busy,
  output logic                          done,
  output logic [cache_pkg::DATA_W-1:0]  load_data,
  output cache_pkg::cpu_req_t           held_req,
  output logic                          line_we,
  output logic                          line_dirty,
  output logic                          hit_update,
  output logic                          fill_start,
  output logic                          wb_start,
  input  logic                          fill_done,
  input  logic                          wb_done
);
  import cache_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        take_req;

  // Busy also covers the done cycle, so a held access is not taken twice
  assign busy = (state != IDLE) || done;
  assign take_req = (state == IDLE) && access && !busy;

  // Store misses will dirty the line on replay anyway
  assign line_dirty = held_req.write;

  always_comb begin
    state_next = state;
    wb_start   = 1'b0;
    fill_start = 1'b0;
    line_we    = 1'b0;
    hit_update = 1'b0;
    case (state)
      IDLE: begin
        if (take_req) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          // Store merge lands at the same edge as done
          hit_update = held_req.write;
          state_next = IDLE;
        end else if (victim_dirty) begin
          wb_start   = 1'b1;
          state_next = WRITE_BACK;
        end else begin
          fill_start = 1'b1;
          state_next = FILL;
        end
      end
      WRITE_BACK: begin
        // Fill goes out right after the victim leaves
        if (wb_done) begin
          fill_start = 1'b1;
          state_next = FILL;
        end
      end
      FILL: begin
        if (fill_done) begin
          state_next = REFILL;
        end
      end
      REFILL: begin
        // Line goes into the victim way, then replay as a hit
        line_we    = 1'b1;
        state_next = LOOKUP;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      done  <= (state == LOOKUP) && hit;
    end
  end

  // Request and load result
  always_ff @(posedge clk) begin
    if (take_req) begin
      held_req <= cpu_req;
    end
    if ((state == LOOKUP) && hit) begin
      load_data <= load_value;
    end
  end

endmodule

/* cache/l1_data_cache.sv */
//==========================================================================
// L1 data cache top
// 4-way write-back, write-allocate cache on the tagged memory bus
//==========================================================================
`timescale 1ns/1ps

module l1_data_cache (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          access,
  input  cache_pkg::cpu_req_t           cpu_req,
  output logic                          busy,
  output logic                          done,
  output logic [cache_pkg::DATA_W-1:0]  load_data,
  output logic                          req_cyc,
  output cache_pkg::bus_req_t           bus_req,
  input  logic                          req_ack,
  input  logic                          resp_cyc,
  input  logic [cache_pkg::DATA_W-1:0]  resp_data,
  output logic                          resp_ack
);
  import cache_pkg::*;

  // Controller side
  cpu_req_t          held_req;
  logic              line_we;
  logic              line_dirty;
  logic              hit_update;
  logic              fill_start;
  logic              wb_start;
  logic              fill_done;
  logic              wb_done;
  logic [DATA_W-1:0] load_value;

  // Array side
  logic              hit;
  logic              victim_dirty;
  logic [TAG_W-1:0]  victim_tag;
  cache_line_t       hit_line;
  cache_line_t       victim_line;
  cache_line_t       fill_line;
  cache_line_t       merged_line;

  cache_ctrl u_cache_ctrl (.*);

  tag_data_array u_tag_data_array (
    .index (held_req.addr.index),
    .tag   (held_req.addr.tag),
    .*
  );

  // Line-aligned fill and victim addresses
  bus_engine u_bus_engine (
    .fill_addr ({held_req.addr.tag, held_req.addr.index, {OFFSET_W{1'b0}}}),
    .wb_addr   ({victim_tag, held_req.addr.index, {OFFSET_W{1'b0}}}),
    .wb_line   (victim_line),
    .*
  );

  load_store_align u_load_store_align (
    .line        (hit_line),
    .offset      (held_req.addr.offset),
    .op          (held_req.op),
    .store_value (held_req.value),
    .*
  );

endmodule

/* bench/tb_l1_data_cache.sv */
//==========================================================================
// L1 data cache testbench
// Bus memory model, byte reference model and directed load/store checks
//==========================================================================
`timescale 1ns/1ps

module tb_l1_data_cache;
  import cache_pkg::*;

  // Cycle budget of 40 cycles per access
  localparam int NUM_ACCESSES = 64;
  localparam int CYCLE_LIMIT  = NUM_ACCESSES * 40;
  // Negedges seen from the drive edge until done on a hit
  localparam int HIT_WAIT     = 3;

  logic              clk;
  logic              reset;
  logic              access;
  cpu_req_t          cpu_req;
  logic              busy;
  logic              done;
  logic [DATA_W-1:0] load_data;
  logic              req_cyc;
  bus_req_t          bus_req;
  logic              req_ack;
  logic              resp_cyc;
  logic [DATA_W-1:0] resp_data;
  logic              resp_ack;

  // Memory keyed by word address and reference bytes keyed by byte address
  logic [63:0] mem_words [longint];
  logic [7:0]  ref_bytes [longint];
  logic [63:0] data_pool [NUM_ACCESSES];

  integer            seed;
  int                cycle_count;
  int                pool_idx;
  int                beats_accepted;
  int                wb_count;
  logic              force_sign;
  logic [ADDR_W-1:0] cur_addr;

  // Bus model state
  logic              in_wb;
  int                wb_beat;
  logic [ADDR_W-1:0] wb_base;
  logic              resp_active;
  logic              resp_wait;
  int                resp_idx;
  logic [ADDR_W-1:0] fill_base;
  logic              hold_prev;
  bus_req_t          prev_req;

  l1_data_cache u_l1_data_cache (.*);

  always #20 clk = ~clk;

  task automatic fail_stop();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%0t: %s", $time, what);
      fail_stop();
    end
  endtask

  // Power-on memory contents hashed from the whole word address
  function automatic logic [63:0] init_word(input logic [ADDR_W-1:0] word_addr);
    return (word_addr * 64'h9E37_79B9_7F4A_7C15) ^ {word_addr[31:0], word_addr[63:32]};
  endfunction

  function automatic logic [63:0] memory_word(input logic [ADDR_W-1:0] addr);
    if (mem_words.exists(addr >> 3)) begin
      return mem_words[addr >> 3];
    end
    return init_word(addr >> 3);
  endfunction

  function automatic logic [7:0] ref_byte(input logic [ADDR_W-1:0] addr);
    logic [63:0] word;
    if (ref_bytes.exists(addr)) begin
      return ref_bytes[addr];
    end
    word = init_word(addr >> 3);
    return word[8*addr[2:0] +: 8];
  endfunction

  function automatic logic [63:0] ref_word(input logic [ADDR_W-1:0] addr);
    logic [63:0] word;
    for (int i = 0; i < 8; i++) begin
      word[8*i +: 8] = ref_byte(addr + i);
    end
    return word;
  endfunction

  function automatic int op_size(input mem_op_e op);
    case (op)
      LW, LWU, SW: return 4;
      LH, LHU, SH: return 2;
      LB, LBU, SB: return 1;
      default:     return 8;
    endcase
  endfunction

  // Little-endian gather, then sign fill for LW, LH, LB
  function automatic logic [63:0] expected_load(input mem_op_e op, input logic [ADDR_W-1:0] addr);
    logic [63:0] raw;
    int          size;
    raw  = '0;
    size = op_size(op);
    for (int i = 0; i < size; i++) begin
      raw[8*i +: 8] = ref_byte(addr + i);
    end
    if ((op == LW || op == LH || op == LB) && raw[8*size-1]) begin
      for (int i = 8 * size; i < 64; i++) begin
        raw[i] = 1'b1;
      end
    end
    return raw;
  endfunction

  function automatic logic [ADDR_W-1:0] line_base(input int tag, input int index);
    return (ADDR_W'(tag) << (OFFSET_W + INDEX_W)) | (ADDR_W'(index) << OFFSET_W);
  endfunction

  // Accepted request beat is a fill address or a write-back beat
  task automatic accept_beat(input bus_req_t beat);
    beats_accepted++;
    if (in_wb) begin
      check_true(beat.tag == MEM_WRITE, "write-back data beat lost its MEM_WRITE tag");
      check_eq("bus_req.data", beat.data, ref_word(wb_base + 8 * wb_beat));
      mem_words[(wb_base >> 3) + wb_beat] = beat.data;
      wb_beat++;
      if (wb_beat == BEATS_PER_LINE) begin
        in_wb = 1'b0;
        wb_count++;
      end
    end else if (beat.tag == MEM_WRITE) begin
      // Victim shares the set of the current access
      check_eq("bus_req.data[7:0]", beat.data[7:0], {cur_addr[7:6], 6'b0});
      in_wb   = 1'b1;
      wb_beat = 0;
      wb_base = beat.data;
    end else begin
      check_true(beat.tag == MEM_READ, "request beat with an unknown bus tag");
      check_eq("bus_req.data", beat.data, {cur_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
      fill_base   = beat.data;
      resp_idx    = 0;
      resp_active = 1'b1;
      resp_wait   = 1'b0;
    end
  endtask

  // Memory model with request and response sides
  always @(posedge clk) begin
    if (!reset) begin
      req_ack     <= 1'b0;
      resp_cyc    <= 1'b0;
      resp_data   <= '0;
      in_wb       = 1'b0;
      resp_active = 1'b0;
      hold_prev   = 1'b0;
    end else begin
      // Stalled beat must hold until acknowledged
      if (hold_prev) begin
        check_true(req_cyc && (bus_req === prev_req),
                   "request beat changed while req_ack was low");
      end
      hold_prev = req_cyc && !req_ack;
      prev_req  = bus_req;
      if (req_cyc && req_ack) begin
        accept_beat(bus_req);
      end
      req_ack <= (($random(seed) & 3) != 0);
      // One response beat per acknowledge
      if (resp_cyc) begin
        resp_cyc  <= 1'b0;
        resp_wait = 1'b1;
      end else if (resp_active && (!resp_wait || resp_ack)) begin
        resp_cyc    <= 1'b1;
        resp_data   <= memory_word(fill_base + 8 * resp_idx);
        resp_idx    = resp_idx + 1;
        resp_wait   = 1'b0;
        resp_active = (resp_idx < BEATS_PER_LINE);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, controller in state %s",
               cycle_count, u_l1_data_cache.u_cache_ctrl.state.name());
      fail_stop();
    end
  end

  // One CPU access checked against the reference bytes
  task automatic do_access(input mem_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic expect_hit);
    logic        is_store;
    logic [63:0] value;
    int          waited;
    int          beats_before;
    is_store = op inside {SD, SW, SH, SB};
    value    = data_pool[pool_idx];
    if (force_sign) begin
      value = value | 64'h8000_0000_8000_8080;
    end
    @(negedge clk);
    check_true(!busy && !done, "cache busy before a new access");
    cur_addr = addr;
    @(posedge clk);
    access        <= 1'b1;
    cpu_req.write <= is_store;
    cpu_req.addr  <= addr;
    cpu_req.value <= value;
    cpu_req.op    <= op;
    beats_before = beats_accepted;
    waited       = 0;
    do begin
      @(negedge clk);
      waited++;
      // Taken at the first edge, busy from then until done
      if (waited >= 2) begin
        check_true(busy, "busy low while an access was in flight");
      end
    end while (!done);
    if (is_store) begin
      for (int i = 0; i < op_size(op); i++) begin
        ref_bytes[addr + i] = value[8*i +: 8];
      end
    end else begin
      check_eq("load_data", load_data, expected_load(op, addr));
    end
    if (expect_hit) begin
      check_true((waited == HIT_WAIT) && (beats_accepted == beats_before),
                 "hit did not finish one cycle after the request was taken");
    end
    @(posedge clk);
    access <= 1'b0;
    pool_idx++;
  endtask

  initial begin : main_seq
    logic [ADDR_W-1:0] line_a;
    logic [ADDR_W-1:0] line_b;
    logic [ADDR_W-1:0] line_c;
    seed           = 11184;
    clk            = 1'b0;
    reset          = 1'b0;
    access         = 1'b0;
    cpu_req        = '0;
    req_ack        = 1'b0;
    resp_cyc       = 1'b0;
    resp_data      = '0;
    cycle_count    = 0;
    pool_idx       = 0;
    beats_accepted = 0;
    wb_count       = 0;
    force_sign     = 1'b0;
    cur_addr       = '0;
    in_wb          = 1'b0;
    wb_beat        = 0;
    wb_base        = '0;
    resp_active    = 1'b0;
    resp_wait      = 1'b0;
    resp_idx       = 0;
    fill_base      = '0;
    hold_prev      = 1'b0;
    prev_req       = '0;
    for (int i = 0; i < NUM_ACCESSES; i++) begin
      data_pool[i] = {$random(seed), $random(seed)};
    end
    repeat (2) @(posedge clk);
    reset <= 1'b1;
    @(negedge clk);
    check_true(!busy && !done && !req_cyc && !resp_ack, "control outputs not low after reset");

    // All load types with a miss first and hits after
    line_a = line_base(1, 0);
    do_access(LD,  line_a + 0,  1'b0);
    do_access(LD,  line_a + 8,  1'b1);
    do_access(LW,  line_a + 4,  1'b1);
    do_access(LH,  line_a + 2,  1'b1);
    do_access(LB,  line_a + 1,  1'b1);
    do_access(LWU, line_a + 12, 1'b1);
    do_access(LHU, line_a + 22, 1'b1);
    do_access(LBU, line_a + 63, 1'b1);
    line_b = line_base(2, 1);
    do_access(LW,  line_b + 60, 1'b0);
    do_access(LH,  line_b + 30, 1'b1);
    do_access(LB,  line_b + 7,  1'b1);
    do_access(LBU, line_b + 7,  1'b1);
    do_access(LHU, line_b + 30, 1'b1);
    do_access(LWU, line_b + 60, 1'b1);
    do_access(LD,  line_b + 56, 1'b1);

    // Store sizes with sign bits set, then same and neighbouring bytes
    force_sign = 1'b1;
    do_access(SD,  line_a + 16, 1'b1);
    do_access(LD,  line_a + 16, 1'b1);
    do_access(LW,  line_a + 16, 1'b1);
    do_access(LW,  line_a + 20, 1'b1);
    do_access(LWU, line_a + 20, 1'b1);
    do_access(SW,  line_a + 24, 1'b1);
    do_access(LW,  line_a + 24, 1'b1);
    do_access(LD,  line_a + 24, 1'b1);
    do_access(LWU, line_a + 28, 1'b1);
    do_access(SH,  line_a + 34, 1'b1);
    do_access(LH,  line_a + 34, 1'b1);
    do_access(LHU, line_a + 34, 1'b1);
    do_access(LD,  line_a + 32, 1'b1);
    do_access(SB,  line_a + 41, 1'b1);
    do_access(LB,  line_a + 41, 1'b1);
    do_access(LBU, line_a + 41, 1'b1);
    do_access(LD,  line_a + 40, 1'b1);
    do_access(LH,  line_a + 40, 1'b1);
    force_sign = 1'b0;

    // Store miss allocates the line
    line_c = line_base(3, 2);
    do_access(SH,  line_c + 6, 1'b0);
    do_access(LD,  line_c + 0, 1'b1);
    do_access(LBU, line_c + 7, 1'b1);

    // Six dirty lines in one set force write-backs, then read them back
    for (int t = 0; t < 6; t++) begin
      do_access(SD, line_base(16 + t, 3) + 8 * t, 1'b0);
    end
    for (int t = 0; t < 6; t++) begin
      do_access(LD, line_base(16 + t, 3) + 8 * t, 1'b0);
    end
    check_true(wb_count >= 2, "fewer than two dirty evictions were written back");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* l1_data_cache.f */
common/cache_pkg.sv
rtl/load_store_align.sv
cache/tag_data_array.sv
cache/bus_engine.sv
cache/cache_ctrl.sv
cache/l1_data_cache.sv
bench/tb_l1_data_cache.sv
